// File: verilog.f
riscv_mw_pkg.sv
riscv_mw_loadext.sv
riscv_mw_ppreg.sv
riscv_mw_wbsel.sv
riscv_mw_top.sv
riscv_mw_tb_clkgen.sv
riscv_mw_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the mem/wb slice testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! rm -rf obj_dir; then
    echo "could not clean obj_dir"
    exit 1
fi

if ! verilator --binary --timing --top-module riscv_mw_tb -f verilog.f; then
    echo "verilator build failed"
    exit 1
fi

if [ ! -x ./obj_dir/Vriscv_mw_tb ]; then
    echo "simulation binary missing"
    exit 1
fi

sim_out=$(./obj_dir/Vriscv_mw_tb 2>&1)
sim_status=$?

printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test OK"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

// File: riscv_mw_tb.sv
`timescale 1ns/100ps

module riscv_mw_tb;

    import riscv_mw_pkg::*;

    typedef struct packed
    {
        riscv_mw_mem_s                 mem;
        logic [riscv_mw_xlen-1:0]      rdata;
        logic                          stall;
        logic                          flush;
        logic                          exp_we;
        logic [riscv_mw_regaddr_w-1:0] exp_addr;
        logic [riscv_mw_xlen-1:0]      exp_data;
        logic                          exp_gototrap;
        logic                          exp_returnfromtrap;
    } row_s;

    logic                          riscv_mw_clk;
    logic                          riscv_mw_rst;
    riscv_mw_mem_s                 mem_in;
    logic [riscv_mw_xlen-1:0]      rdata_in;
    logic                          stall_in;
    logic                          flush_in;
    logic                          rfwe;
    logic [riscv_mw_regaddr_w-1:0] rfaddr;
    logic [riscv_mw_xlen-1:0]      rfdata;
    logic                          gototrap_wb;
    logic                          returnfromtrap_wb;

    row_s rows[$];
    logic table_ready;

    riscv_mw_tb_clkgen u_clkgen
    (
        .o_riscv_mw_clk (riscv_mw_clk),
        .o_riscv_mw_rst (riscv_mw_rst)
    );

    riscv_mw_top UUT
    (
        .i_riscv_mw_clk               (riscv_mw_clk),
        .i_riscv_mw_rst               (riscv_mw_rst),
        .i_riscv_mw_mem               (mem_in),
        .i_riscv_mw_rdata             (rdata_in),
        .i_riscv_mw_stall             (stall_in),
        .i_riscv_mw_flush             (flush_in),
        .o_riscv_mw_rfwe              (rfwe),
        .o_riscv_mw_rfaddr            (rfaddr),
        .o_riscv_mw_rfdata            (rfdata),
        .o_riscv_mw_gototrap_wb       (gototrap_wb),
        .o_riscv_mw_returnfromtrap_wb (returnfromtrap_wb)
    );

    function automatic logic [63:0] random_dword();
        return {$urandom, $urandom};
    endfunction

    // width and signedness per load type, field masked out of the shifted word
    function automatic logic [63:0] expect_load(input logic [63:0] raw, input logic [2:0] off,
                                                input riscv_mw_load_e lt);
        logic [63:0] fld;
        logic [63:0] mask;
        int          nbits;
        logic        sgn;
        case (lt)
            lb, lbu: nbits = 8;
            lh, lhu: nbits = 16;
            lw, lwu: nbits = 32;
            ld:      nbits = 64;
            default: nbits = 0;
        endcase
        sgn = (lt == lb) || (lt == lh) || (lt == lw);
        if (nbits == 0)
            return 64'd0;
        if (nbits == 64)
            return raw;
        fld  = raw >> (off * 8);
        mask = (64'd1 << nbits) - 64'd1;
        fld  = fld & mask;
        if (sgn && fld[nbits-1])
            fld = fld | ~mask;      // sign fill
        return fld;
    endfunction

    function automatic logic [63:0] expect_data(input riscv_mw_mem_s m, input logic [63:0] ld_val);
        if (m.iscsr)
            return m.csrout;
        case (m.resultsrc)
            src_mem:  return ld_val;
            src_pc4:  return m.pcplus4;
            src_uimm: return m.uimm;
            default:  return m.result;
        endcase
    endfunction

    function automatic riscv_mw_mem_s random_mem();
        riscv_mw_mem_s m;
        m.pcplus4        = random_dword();
        m.result         = random_dword();
        m.uimm           = random_dword();
        m.rdaddr         = 5'($urandom % 31 + 1);   // never x0
        m.resultsrc      = src_alu;
        m.loadtype       = riscv_mw_load_e'(3'($urandom % 7));
        m.regw           = 1'b1;
        m.csrout         = random_dword();
        m.iscsr          = 1'b0;
        m.gototrap       = 1'b0;
        m.returnfromtrap = 1'b0;
        return m;
    endfunction

    task automatic add_row(input riscv_mw_mem_s m, input logic [63:0] raw,
                           input logic stall, input logic flush);
        row_s r;
        r       = '0;
        r.mem   = m;
        r.rdata = raw;
        r.stall = stall;
        r.flush = flush;
        if (flush)
        begin
            r.exp_we = 1'b0;        // bubble, rest already zero
        end
        else if (stall)
        begin
            if (rows.size() > 0)
            begin
                r.exp_we             = rows[rows.size()-1].exp_we;
                r.exp_addr           = rows[rows.size()-1].exp_addr;
                r.exp_data           = rows[rows.size()-1].exp_data;
                r.exp_gototrap       = rows[rows.size()-1].exp_gototrap;
                r.exp_returnfromtrap = rows[rows.size()-1].exp_returnfromtrap;
            end
        end
        else
        begin
            r.exp_we             = m.regw && (m.rdaddr != 5'd0);
            r.exp_addr           = m.rdaddr;
            r.exp_data           = expect_data(m, expect_load(raw, m.result[2:0], m.loadtype));
            r.exp_gototrap       = m.gototrap;
            r.exp_returnfromtrap = m.returnfromtrap;
        end
        rows.push_back(r);
    endtask

    task automatic add_load(input riscv_mw_load_e lt, input logic [2:0] off,
                            input logic [63:0] raw);
        riscv_mw_mem_s m;
        m            = random_mem();
        m.resultsrc  = src_mem;
        m.loadtype   = lt;
        m.result[2:0] = off;
        add_row(m, raw, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        riscv_mw_mem_s m;
        logic [63:0]   pat_a;
        logic [63:0]   pat_b;
        pat_a = 64'hf1e2_d3c4_b5a6_9788;
        pat_b = random_dword() | 64'h8080_8080_8080_8080;  // every byte negative
        m = random_mem();
        add_row(m, random_dword(), 1'b0, 1'b0);
        m = random_mem();
        m.resultsrc = src_pc4;
        add_row(m, random_dword(), 1'b0, 1'b0);
        m = random_mem();
        m.resultsrc = src_uimm;
        add_row(m, random_dword(), 1'b0, 1'b0);
        m = random_mem();
        m.rdaddr = 5'd0;            // write to x0 dropped
        add_row(m, random_dword(), 1'b0, 1'b0);
        m = random_mem();
        m.regw = 1'b0;
        add_row(m, random_dword(), 1'b0, 1'b0);
        add_load(lb, 3'd0, pat_a);
        add_load(lb, 3'd3, pat_a);
        add_load(lb, 3'd7, pat_b);
        add_load(lbu, 3'd1, pat_a);
        add_load(lbu, 3'd7, pat_b);
        add_load(lh, 3'd0, pat_a);
        add_load(lh, 3'd2, pat_b);
        add_load(lh, 3'd6, pat_a);
        add_load(lhu, 3'd4, pat_a);
        add_load(lhu, 3'd6, pat_b);
        add_load(lw, 3'd0, pat_a);
        add_load(lw, 3'd4, pat_b);
        add_load(lw, 3'd4, 64'h7f6e_5d4c_3b2a_1908);    // positive word
        add_load(lwu, 3'd0, pat_b);
        add_load(lwu, 3'd4, pat_a);
        add_load(ld, 3'd0, pat_a);
        add_load(ld, 3'd0, pat_b);
        for (int s = 0; s < 4; s++)
        begin
            m = random_mem();
            m.iscsr = 1'b1;
            m.resultsrc = riscv_mw_resultsrc_e'(2'(s));
            add_row(m, random_dword(), 1'b0, 1'b0);
        end
        m = random_mem();
        m.gototrap = 1'b1;
        add_row(m, random_dword(), 1'b0, 1'b0);
        m = random_mem();
        m.returnfromtrap = 1'b1;
        add_row(m, random_dword(), 1'b0, 1'b0);
        m = random_mem();
        m.gototrap = 1'b1;
        m.returnfromtrap = 1'b1;
        add_row(m, random_dword(), 1'b0, 1'b0);
        m = random_mem();
        add_row(m, random_dword(), 1'b0, 1'b0);
        add_row(random_mem(), random_dword(), 1'b1, 1'b0);  // new inputs lost
        add_row(random_mem(), random_dword(), 1'b1, 1'b0);
        add_row(random_mem(), random_dword(), 1'b0, 1'b0);
        add_row(random_mem(), random_dword(), 1'b0, 1'b1);
        add_row(random_mem(), random_dword(), 1'b0, 1'b0);
        add_row(random_mem(), random_dword(), 1'b1, 1'b1);  // flush wins
        add_row(random_mem(), random_dword(), 1'b0, 1'b0);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic check_row(input int i);
        check_value($sformatf("row %0d rfwe", i), 64'(rfwe), 64'(rows[i].exp_we));
        check_value($sformatf("row %0d rfaddr", i), 64'(rfaddr), 64'(rows[i].exp_addr));
        check_value($sformatf("row %0d rfdata", i), rfdata, rows[i].exp_data);
        check_value($sformatf("row %0d gototrap", i), 64'(gototrap_wb),
                    64'(rows[i].exp_gototrap));
        check_value($sformatf("row %0d returnfromtrap", i), 64'(returnfromtrap_wb),
                    64'(rows[i].exp_returnfromtrap));
    endtask

    initial
    begin
        void'($urandom(19));
        table_ready = 1'b0;
        mem_in      = '0;
        rdata_in    = '0;
        stall_in    = 1'b0;
        flush_in    = 1'b0;
        build_table();
        table_ready = 1'b1;
        @(negedge riscv_mw_rst);
        check_value("reset rfwe", 64'(rfwe), 64'd0);
        check_value("reset rfdata", rfdata, 64'd0);
        check_value("reset gototrap", 64'(gototrap_wb), 64'd0);
        check_value("reset returnfromtrap", 64'(returnfromtrap_wb), 64'd0);
        for (int i = 0; i < rows.size(); i++)
        begin
            mem_in   = rows[i].mem;     // 1 ns after the edge
            rdata_in = rows[i].rdata;
            stall_in = rows[i].stall;
            flush_in = rows[i].flush;
            @(posedge riscv_mw_clk);
            #1;
            check_row(i);
        end
        $display("Test OK");
        $finish;
    end

    // run length bound from the table size
    initial
    begin
        wait (table_ready);
        #((rows.size() + 10) * 10);
        $display("timeout: the stimulus table did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: riscv_mw_tb_clkgen.sv
`timescale 1ns/100ps

module riscv_mw_tb_clkgen
(
    output logic o_riscv_mw_clk,
    output logic o_riscv_mw_rst
);

    initial
    begin
        o_riscv_mw_clk = 1'b0;
        forever #5 o_riscv_mw_clk = ~o_riscv_mw_clk;    // 10 ns period
    end

    // reset held over the first two rising edges
    initial
    begin
        o_riscv_mw_rst = 1'b1;
        repeat (2) @(posedge o_riscv_mw_clk);
        #1 o_riscv_mw_rst = 1'b0;
    end

endmodule

// File: riscv_mw_top.sv
`timescale 1ns/100ps

module riscv_mw_top
(
    input  logic                                        i_riscv_mw_clk,
    input  logic                                        i_riscv_mw_rst,
    input  riscv_mw_pkg::riscv_mw_mem_s                 i_riscv_mw_mem,
    input  logic [riscv_mw_pkg::riscv_mw_xlen-1:0]      i_riscv_mw_rdata,
    input  logic                                        i_riscv_mw_stall,
    input  logic                                        i_riscv_mw_flush,
    output logic                                        o_riscv_mw_rfwe,
    output logic [riscv_mw_pkg::riscv_mw_regaddr_w-1:0] o_riscv_mw_rfaddr,
    output logic [riscv_mw_pkg::riscv_mw_xlen-1:0]      o_riscv_mw_rfdata,
    output logic                                        o_riscv_mw_gototrap_wb,
    output logic                                        o_riscv_mw_returnfromtrap_wb
);

    import riscv_mw_pkg::*;

    logic [riscv_mw_xlen-1:0] memload;
    riscv_mw_wb_s             mw_d;        // register input
    riscv_mw_wb_s             mw_q;        // register output

    riscv_mw_loadext u_loadext
    (
        .i_riscv_mw_rdata    (i_riscv_mw_rdata),
        .i_riscv_mw_byteoff  (i_riscv_mw_mem.result[2:0]),
        .i_riscv_mw_loadtype (i_riscv_mw_mem.loadtype),
        .o_riscv_mw_memload  (memload)
    );

    // loadtype is consumed here, memload takes its place
    assign mw_d.pcplus4        = i_riscv_mw_mem.pcplus4;
    assign mw_d.result         = i_riscv_mw_mem.result;
    assign mw_d.uimm           = i_riscv_mw_mem.uimm;
    assign mw_d.rdaddr         = i_riscv_mw_mem.rdaddr;
    assign mw_d.resultsrc      = i_riscv_mw_mem.resultsrc;
    assign mw_d.memload        = memload;
    assign mw_d.regw           = i_riscv_mw_mem.regw;
    assign mw_d.csrout         = i_riscv_mw_mem.csrout;
    assign mw_d.iscsr          = i_riscv_mw_mem.iscsr;
    assign mw_d.gototrap       = i_riscv_mw_mem.gototrap;
    assign mw_d.returnfromtrap = i_riscv_mw_mem.returnfromtrap;

    riscv_mw_ppreg u_ppreg
    (
        .i_riscv_mw_clk   (i_riscv_mw_clk),
        .i_riscv_mw_rst   (i_riscv_mw_rst),
        .i_riscv_mw_stall (i_riscv_mw_stall),
        .i_riscv_mw_flush (i_riscv_mw_flush),
        .i_riscv_mw_m     (mw_d),
        .o_riscv_mw_wb    (mw_q)
    );

    riscv_mw_wbsel u_wbsel
    (
        .i_riscv_mw_wb                (mw_q),
        .o_riscv_mw_rfwe              (o_riscv_mw_rfwe),
        .o_riscv_mw_rfaddr            (o_riscv_mw_rfaddr),
        .o_riscv_mw_rfdata            (o_riscv_mw_rfdata),
        .o_riscv_mw_gototrap_wb       (o_riscv_mw_gototrap_wb),
        .o_riscv_mw_returnfromtrap_wb (o_riscv_mw_returnfromtrap_wb)
    );

endmodule

// File: riscv_mw_wbsel.sv
`timescale 1ns/100ps

module riscv_mw_wbsel
(
    input  riscv_mw_pkg::riscv_mw_wb_s                  i_riscv_mw_wb,
    output logic                                        o_riscv_mw_rfwe,
    output logic [riscv_mw_pkg::riscv_mw_regaddr_w-1:0] o_riscv_mw_rfaddr,
    output logic [riscv_mw_pkg::riscv_mw_xlen-1:0]      o_riscv_mw_rfdata,
    output logic                                        o_riscv_mw_gototrap_wb,
    output logic                                        o_riscv_mw_returnfromtrap_wb
);

    import riscv_mw_pkg::*;

    logic [riscv_mw_xlen-1:0] src_data;

    // normal result mux
    always_comb
    begin
        src_data = i_riscv_mw_wb.result;
        case (i_riscv_mw_wb.resultsrc)
            src_alu:  src_data = i_riscv_mw_wb.result;
            src_mem:  src_data = i_riscv_mw_wb.memload;
            src_pc4:  src_data = i_riscv_mw_wb.pcplus4;
            src_uimm: src_data = i_riscv_mw_wb.uimm;    // lui
            default:  src_data = i_riscv_mw_wb.result;
        endcase
    end

    // csr read value overrides the source mux
    assign o_riscv_mw_rfdata = i_riscv_mw_wb.iscsr ? i_riscv_mw_wb.csrout : src_data;

    assign o_riscv_mw_rfaddr = i_riscv_mw_wb.rdaddr;
    assign o_riscv_mw_rfwe   = i_riscv_mw_wb.regw && (i_riscv_mw_wb.rdaddr != '0);   // x0 stays 0

    assign o_riscv_mw_gototrap_wb       = i_riscv_mw_wb.gototrap;
    assign o_riscv_mw_returnfromtrap_wb = i_riscv_mw_wb.returnfromtrap;

endmodule

// File: riscv_mw_ppreg.sv
`timescale 1ns/100ps

module riscv_mw_ppreg
(
    input  logic                       i_riscv_mw_clk,
    input  logic                       i_riscv_mw_rst,
    input  logic                       i_riscv_mw_stall,
    input  logic                       i_riscv_mw_flush,
    input  riscv_mw_pkg::riscv_mw_wb_s i_riscv_mw_m,
    output riscv_mw_pkg::riscv_mw_wb_s o_riscv_mw_wb
);

    import riscv_mw_pkg::*;

    riscv_mw_wb_s wb_q;

    // flush beats stall, stall holds everything
    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst)
    begin
        if (i_riscv_mw_rst)
        begin
            wb_q <= '0;
        end
        else if (i_riscv_mw_flush)
        begin
            wb_q <= '0;                 // bubble, regw and trap flags drop
        end
        else if (!i_riscv_mw_stall)
        begin
            wb_q <= i_riscv_mw_m;
        end
    end

    assign o_riscv_mw_wb = wb_q;

endmodule

// File: riscv_mw_loadext.sv
`timescale 1ns/100ps

module riscv_mw_loadext
(
    input  logic [riscv_mw_pkg::riscv_mw_xlen-1:0] i_riscv_mw_rdata,
    input  logic [2:0]                             i_riscv_mw_byteoff,
    input  riscv_mw_pkg::riscv_mw_load_e           i_riscv_mw_loadtype,
    output logic [riscv_mw_pkg::riscv_mw_xlen-1:0] o_riscv_mw_memload
);

    import riscv_mw_pkg::*;

    logic [riscv_mw_xlen-1:0] shifted;
    logic [7:0]               sel_b;
    logic [15:0]              sel_h;
    logic [31:0]              sel_w;

    // byte offset times 8, field lands at bit 0
    assign shifted = i_riscv_mw_rdata >> {i_riscv_mw_byteoff, 3'b000};

    assign sel_b = shifted[7:0];
    assign sel_h = shifted[15:0];
    assign sel_w = shifted[31:0];

    always_comb
    begin
        case (i_riscv_mw_loadtype)
            lb:
            begin
                o_riscv_mw_memload = {{(riscv_mw_xlen-8){sel_b[7]}}, sel_b};
            end
            lh:
            begin
                o_riscv_mw_memload = {{(riscv_mw_xlen-16){sel_h[15]}}, sel_h};
            end
            lw:
            begin
                o_riscv_mw_memload = {{(riscv_mw_xlen-32){sel_w[31]}}, sel_w};
            end
            ld:
            begin
                o_riscv_mw_memload = i_riscv_mw_rdata;     // aligned, no shift
            end
            lbu:
            begin
                o_riscv_mw_memload = {{(riscv_mw_xlen-8){1'b0}}, sel_b};
            end
            lhu:
            begin
                o_riscv_mw_memload = {{(riscv_mw_xlen-16){1'b0}}, sel_h};
            end
            lwu:
            begin
                o_riscv_mw_memload = {{(riscv_mw_xlen-32){1'b0}}, sel_w};
            end
            default:
            begin
                o_riscv_mw_memload = '0;                  // 3'b111 is not a load
            end
        endcase
    end

endmodule

// File: riscv_mw_pkg.sv
package riscv_mw_pkg;

    localparam int riscv_mw_xlen      = 64;    // data path width
    localparam int riscv_mw_regaddr_w = 5;     // x0..x31

    // load type, same encoding as funct3 of the load opcode
    typedef enum logic [2:0]
    {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } riscv_mw_load_e;

    // writeback source select
    typedef enum logic [1:0]
    {
        src_alu  = 2'b00,
        src_mem  = 2'b01,
        src_pc4  = 2'b10,
        src_uimm = 2'b11
    } riscv_mw_resultsrc_e;

    // bundle leaving the memory stage
    typedef struct packed
    {
        logic [riscv_mw_xlen-1:0]      pcplus4;
        logic [riscv_mw_xlen-1:0]      result;          // alu result, also load address
        logic [riscv_mw_xlen-1:0]      uimm;
        logic [riscv_mw_regaddr_w-1:0] rdaddr;
        riscv_mw_resultsrc_e           resultsrc;
        riscv_mw_load_e                loadtype;
        logic                          regw;
        logic [riscv_mw_xlen-1:0]      csrout;
        logic                          iscsr;
        logic                          gototrap;
        logic                          returnfromtrap;
    } riscv_mw_mem_s;

    // bundle held in the mem/wb register
    typedef struct packed
    {
        logic [riscv_mw_xlen-1:0]      pcplus4;
        logic [riscv_mw_xlen-1:0]      result;
        logic [riscv_mw_xlen-1:0]      uimm;
        logic [riscv_mw_regaddr_w-1:0] rdaddr;
        riscv_mw_resultsrc_e           resultsrc;
        logic [riscv_mw_xlen-1:0]      memload;         // already aligned and extended
        logic                          regw;
        logic [riscv_mw_xlen-1:0]      csrout;
        logic                          iscsr;
        logic                          gototrap;
        logic                          returnfromtrap;
    } riscv_mw_wb_s;

endpackage
